//--- design/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath widths
`define EX_WORD_W 32
`define EX_MM_W 64
`define EX_REG_W 3

// code segment selector width
`define EX_SEL_W 16

// shift count taken from the low bits of b
`define EX_SHAMT_W 5

// x86 EFLAGS bit positions
`define EX_FLAG_CF 0
`define EX_FLAG_ZF 6
`define EX_FLAG_SF 7
`define EX_FLAG_OF 11

`endif

//--- design/ex_data_pkg.sv
`include "ex_defs.svh"

package ex_data_pkg;

  // general purpose operand
  typedef logic [`EX_WORD_W-1:0] word_t;

  // packed MMX register
  typedef logic [`EX_MM_W-1:0] mm_t;

  // destination register number
  typedef logic [`EX_REG_W-1:0] reg_num_t;

  // linear address and next eip
  typedef logic [`EX_WORD_W-1:0] addr_t;

  // EFLAGS word, only CF ZF SF OF are computed here
  typedef logic [`EX_WORD_W-1:0] flags_t;

endpackage

//--- design/ex_ctrl_pkg.sv
`include "ex_defs.svh"

package ex_ctrl_pkg;

  typedef enum logic [2:0] {
    alu_add    = 3'd0,
    alu_adc    = 3'd1,
    alu_sub    = 3'd2,
    alu_and    = 3'd3,
    alu_or     = 3'd4,
    alu_xor    = 3'd5,
    alu_not    = 3'd6,
    alu_pass_b = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    shift_shl = 2'd0,
    shift_shr = 2'd1,
    shift_sar = 2'd2
  } shift_op_t;

  typedef enum logic [1:0] {
    size8  = 2'd0,
    size16 = 2'd1,
    size32 = 2'd2
  } datasize_t;

  // control store fields used by execute
  typedef struct packed {
    logic      is_alu32;
    logic      is_shift;
    shift_op_t shift_op;
    logic      is_cmpxchg;
    logic      is_xchg;
    logic      is_cmps_first;
    logic      is_cmps_second;
    logic      pass_a;
    logic      mux_sp_pop;
    logic      ld_gpr1;
    logic      ld_gpr2;
    logic      ld_gpr3;
    logic      ld_seg;
    logic      ld_mm;
    logic      dcache_write;
    logic      repne;
  } ex_ctrl_t;

  typedef struct packed {
    logic                    valid;
    ex_data_pkg::addr_t      neip;
    logic [`EX_SEL_W-1:0]    ncs;
    ex_ctrl_t                ctrl;
    alu_op_t                 aluk;
    datasize_t               datasize;
    ex_data_pkg::word_t      a;
    ex_data_pkg::word_t      b;
    ex_data_pkg::word_t      c;
    ex_data_pkg::mm_t        mm_a;
    ex_data_pkg::mm_t        mm_b;
    ex_data_pkg::reg_num_t   dr1;
    ex_data_pkg::reg_num_t   dr2;
    ex_data_pkg::reg_num_t   dr3;
    ex_data_pkg::addr_t      address;
  } ex_bundle_t;

  typedef struct packed {
    logic                    valid;
    ex_data_pkg::addr_t      neip;
    logic [`EX_SEL_W-1:0]    ncs;
    ex_ctrl_t                ctrl;
    datasize_t               datasize;
    logic                    ld_gpr1;
    logic                    ld_gpr2;
    logic                    dcache_write;
    ex_data_pkg::word_t      result_a;
    ex_data_pkg::word_t      result_b;
    ex_data_pkg::word_t      result_c;
    ex_data_pkg::flags_t     flags;
    ex_data_pkg::mm_t        result_mm;
    ex_data_pkg::reg_num_t   dr1;
    ex_data_pkg::reg_num_t   dr2;
    ex_data_pkg::reg_num_t   dr3;
    ex_data_pkg::addr_t      address;
  } wb_bundle_t;

  // valid-qualified enables for the dependency check
  typedef struct packed {
    logic gpr1;
    logic gpr2;
    logic gpr3;
    logic seg;
    logic mm;
    logic dcache_write;
  } dep_enables_t;

endpackage

//--- design/operand_select_ex.sv
`timescale 1ns/1ps

module operand_select_ex (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  ex_ctrl_pkg::ex_ctrl_t ctrl,
  input  logic                  valid,
  input  logic                  ld_latches,
  input  ex_data_pkg::word_t    b_in,
  input  ex_data_pkg::word_t    c_in,
  input  ex_data_pkg::word_t    count_fwd,
  output ex_data_pkg::word_t    b_eff,
  output ex_data_pkg::word_t    count
);

  import ex_data_pkg::*;

  // first CMPS uop operand, compared against on the second uop
  word_t cmps_b_q;
  logic  cmps_load;

  assign cmps_load = valid & ld_latches & ctrl.is_cmps_first;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cmps_b_q <= '0;
    end else if (cmps_load) begin
      cmps_b_q <= b_in;
    end
  end

  always_comb begin
    if (ctrl.is_cmps_second) begin
      b_eff = cmps_b_q;
    end else begin
      b_eff = b_in;
    end

    // repne steady state takes the count from writeback forwarding
    if (ctrl.repne) begin
      count = count_fwd;
    end else begin
      count = c_in;
    end
  end

endmodule

//--- design/functional_unit_ex.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module functional_unit_ex (
  input  ex_ctrl_pkg::alu_op_t   aluk,
  input  ex_ctrl_pkg::datasize_t datasize,
  input  ex_ctrl_pkg::ex_ctrl_t  ctrl,
  input  ex_data_pkg::word_t     a,
  input  ex_data_pkg::word_t     b_eff,
  input  ex_data_pkg::word_t     c,
  input  ex_data_pkg::word_t     count,
  input  ex_data_pkg::flags_t    flags_fwd,
  input  ex_data_pkg::mm_t       mm_a,
  input  ex_data_pkg::mm_t       mm_b,
  output ex_data_pkg::word_t     alu_result,
  output ex_data_pkg::flags_t    alu_flags,
  output ex_data_pkg::word_t     shift_result,
  output ex_data_pkg::flags_t    shift_flags,
  output ex_data_pkg::word_t     count_minus_one,
  output ex_data_pkg::word_t     sp_pop,
  output ex_data_pkg::mm_t       mm_result
);

  import ex_data_pkg::*;
  import ex_ctrl_pkg::*;

  localparam int lane_w = 16;
  localparam int lanes  = `EX_MM_W / lane_w;

  alu_op_t                 op;
  word_t                   op_x;
  word_t                   op_y;
  word_t                   mask;
  word_t                   x_m;
  word_t                   y_m;
  logic [`EX_WORD_W:0]     raw;
  logic                    sx;
  logic                    sy;
  logic                    sr;
  logic                    cf;
  logic                    of;
  logic [`EX_SHAMT_W-1:0]  shamt;
  logic [`EX_WORD_W:0]     wide;
  word_t                   sh_res;
  logic                    sh_cf;
  logic                    sh_of;

  // sign bit of the active operand size
  function automatic logic sign_of(input word_t v, input datasize_t ds);
    case (ds)
      size8:   return v[7];
      size16:  return v[15];
      default: return v[`EX_WORD_W-1];
    endcase
  endfunction

  // cmpxchg compares accumulator c against a
  always_comb begin
    op   = ctrl.is_cmpxchg ? alu_sub : aluk;
    op_x = ctrl.is_cmpxchg ? c : a;
    op_y = ctrl.is_cmpxchg ? a : b_eff;
    case (datasize)
      size8:   mask = word_t'(8'hff);
      size16:  mask = word_t'(16'hffff);
      default: mask = '1;
    endcase
    x_m = op_x & mask;
    y_m = op_y & mask;

    case (op)
      alu_add:    raw = {1'b0, x_m} + {1'b0, y_m};
      alu_adc:    raw = {1'b0, x_m} + {1'b0, y_m} + flags_fwd[`EX_FLAG_CF];
      alu_sub:    raw = {1'b0, x_m} - {1'b0, y_m};
      alu_and:    raw = {1'b0, x_m & y_m};
      alu_or:     raw = {1'b0, x_m | y_m};
      alu_xor:    raw = {1'b0, x_m ^ y_m};
      alu_not:    raw = {1'b0, ~x_m};
      alu_pass_b: raw = {1'b0, y_m};
      default:    raw = '0;
    endcase
    alu_result = raw[`EX_WORD_W-1:0] & mask;

    sx = sign_of(x_m, datasize);
    sy = sign_of(y_m, datasize);
    sr = sign_of(alu_result, datasize);

    // carry out of the datasize top bit, logic ops clear CF and OF
    cf = 1'b0;
    of = 1'b0;
    if (op == alu_add || op == alu_adc || op == alu_sub) begin
      case (datasize)
        size8:   cf = raw[8];
        size16:  cf = raw[16];
        default: cf = raw[`EX_WORD_W];
      endcase
      if (op == alu_sub) begin
        of = (sx != sy) && (sr != sx);
      end else begin
        of = (sx == sy) && (sr != sx);
      end
    end

    alu_flags              = flags_fwd;
    alu_flags[`EX_FLAG_CF] = cf;
    alu_flags[`EX_FLAG_ZF] = (alu_result == '0);
    alu_flags[`EX_FLAG_SF] = sr;
    alu_flags[`EX_FLAG_OF] = of;
  end

  // shifter, CF is the last bit shifted out
  always_comb begin
    shamt = b_eff[`EX_SHAMT_W-1:0];
    case (ctrl.shift_op)
      shift_shl: begin
        wide   = {1'b0, a} << shamt;
        sh_res = wide[`EX_WORD_W-1:0];
        sh_cf  = wide[`EX_WORD_W];
        sh_of  = sh_res[`EX_WORD_W-1] ^ sh_cf;
      end
      shift_shr: begin
        wide   = {a, 1'b0} >> shamt;
        sh_res = wide[`EX_WORD_W:1];
        sh_cf  = wide[0];
        sh_of  = a[`EX_WORD_W-1];
      end
      default: begin
        wide   = $signed({a, 1'b0}) >>> shamt;
        sh_res = wide[`EX_WORD_W:1];
        sh_cf  = wide[0];
        sh_of  = 1'b0;
      end
    endcase

    if (shamt == '0) begin
      shift_result = a;
      shift_flags  = flags_fwd;
    end else begin
      shift_result             = sh_res;
      shift_flags              = flags_fwd;
      shift_flags[`EX_FLAG_CF] = sh_cf;
      shift_flags[`EX_FLAG_ZF] = (sh_res == '0);
      shift_flags[`EX_FLAG_SF] = sh_res[`EX_WORD_W-1];
      shift_flags[`EX_FLAG_OF] = sh_of;
    end
  end

  assign count_minus_one = count - word_t'(1);

  // pop adjusts esp by the operand size
  assign sp_pop = a + ((datasize == size16) ? word_t'(2) : word_t'(4));

  // paddw, no carry between lanes
  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      mm_result[i*lane_w +: lane_w] = mm_a[i*lane_w +: lane_w] + mm_b[i*lane_w +: lane_w];
    end
  end

endmodule

//--- design/result_select_ex.sv
`timescale 1ns/1ps

module result_select_ex (
  input  ex_ctrl_pkg::ex_ctrl_t ctrl,
  input  ex_data_pkg::word_t    a,
  input  ex_data_pkg::word_t    b_eff,
  input  ex_data_pkg::word_t    c,
  input  ex_data_pkg::flags_t   flags_fwd,
  input  ex_data_pkg::word_t    alu_result,
  input  ex_data_pkg::flags_t   alu_flags,
  input  ex_data_pkg::word_t    shift_result,
  input  ex_data_pkg::flags_t   shift_flags,
  input  ex_data_pkg::word_t    count_minus_one,
  input  ex_data_pkg::word_t    sp_pop,
  input  ex_data_pkg::mm_t      mm_result,
  output ex_data_pkg::word_t    result_a,
  output ex_data_pkg::word_t    result_b,
  output ex_data_pkg::word_t    result_c,
  output ex_data_pkg::flags_t   flags,
  output ex_data_pkg::mm_t      result_mm
);

  always_comb begin
    // shift wins over alu, then xchg swap
    if (ctrl.is_shift) begin
      result_a = shift_result;
    end else if (ctrl.is_alu32) begin
      result_a = alu_result;
    end else if (ctrl.is_xchg) begin
      result_a = b_eff;
    end else begin
      result_a = a;
    end

    // xchg and cmpxchg both return the old a through b
    if (ctrl.is_xchg || ctrl.is_cmpxchg) begin
      result_b = a;
    end else if (ctrl.mux_sp_pop) begin
      result_b = sp_pop;
    end else begin
      result_b = b_eff;
    end

    // string ops step the count register
    if (ctrl.repne || ctrl.is_cmps_second) begin
      result_c = count_minus_one;
    end else begin
      result_c = c;
    end

    if (ctrl.is_shift) begin
      flags = shift_flags;
    end else if (ctrl.is_alu32) begin
      flags = alu_flags;
    end else begin
      flags = flags_fwd;
    end
  end

  assign result_mm = mm_result;

endmodule

//--- design/write_enable_ex.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module write_enable_ex (
  input  ex_ctrl_pkg::ex_ctrl_t     ctrl,
  input  logic                      valid,
  input  ex_data_pkg::flags_t       alu_flags,
  output logic                      ld_gpr1,
  output logic                      ld_gpr2,
  output logic                      dcache_write,
  output ex_ctrl_pkg::dep_enables_t dep
);

  always_comb begin
    if (ctrl.is_cmpxchg) begin
      if (alu_flags[`EX_FLAG_ZF]) begin
        // equal, store the source into the destination
        ld_gpr1      = ctrl.ld_gpr1;
        ld_gpr2      = 1'b0;
        dcache_write = ctrl.dcache_write;
      end else begin
        // not equal, load the accumulator instead
        ld_gpr1      = 1'b0;
        ld_gpr2      = 1'b1;
        dcache_write = 1'b0;
      end
    end else begin
      ld_gpr1      = ctrl.ld_gpr1;
      ld_gpr2      = ctrl.ld_gpr2;
      dcache_write = ctrl.dcache_write;
    end
  end

  // a bubble in ex must not block younger uops
  always_comb begin
    dep.gpr1         = ld_gpr1 & valid;
    dep.gpr2         = ld_gpr2 & valid;
    dep.gpr3         = ctrl.ld_gpr3 & valid;
    dep.seg          = ctrl.ld_seg & valid;
    dep.mm           = ctrl.ld_mm & valid;
    dep.dcache_write = dcache_write & valid;
  end

endmodule

//--- design/ex_wb_latch.sv
`timescale 1ns/1ps

module ex_wb_latch (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  ex_ctrl_pkg::wb_bundle_t next,
  input  logic                    repne,
  input  logic                    repne_terminate,
  input  logic                    wb_stall,
  output ex_ctrl_pkg::wb_bundle_t wb,
  output logic                    ld_latches
);

  import ex_ctrl_pkg::*;

  logic         valid_next;
  logic         valid_q;
  logic [2:0]   en_q;
  dep_enables_t ctrl_en_q;
  wb_bundle_t   data_q;

  assign ld_latches = ~wb_stall;

  // terminated repne iteration leaves a bubble
  assign valid_next = next.valid & ~(repne & repne_terminate);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= 1'b0;
      en_q      <= '0;
      ctrl_en_q <= '0;
    end else if (ld_latches) begin
      valid_q                <= valid_next;
      en_q                   <= {next.ld_gpr1, next.ld_gpr2, next.dcache_write};
      ctrl_en_q.gpr1         <= next.ctrl.ld_gpr1;
      ctrl_en_q.gpr2         <= next.ctrl.ld_gpr2;
      ctrl_en_q.gpr3         <= next.ctrl.ld_gpr3;
      ctrl_en_q.seg          <= next.ctrl.ld_seg;
      ctrl_en_q.mm           <= next.ctrl.ld_mm;
      ctrl_en_q.dcache_write <= next.ctrl.dcache_write;
    end
  end

  always_ff @(posedge CLK) begin
    if (ld_latches) begin
      data_q <= next;
    end
  end

  always_comb begin
    wb                   = data_q;
    wb.valid             = valid_q;
    wb.ld_gpr1           = en_q[2];
    wb.ld_gpr2           = en_q[1];
    wb.dcache_write      = en_q[0];
    wb.ctrl.ld_gpr1      = ctrl_en_q.gpr1;
    wb.ctrl.ld_gpr2      = ctrl_en_q.gpr2;
    wb.ctrl.ld_gpr3      = ctrl_en_q.gpr3;
    wb.ctrl.ld_seg       = ctrl_en_q.seg;
    wb.ctrl.ld_mm        = ctrl_en_q.mm;
    wb.ctrl.dcache_write = ctrl_en_q.dcache_write;
  end

endmodule

//--- design/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  ex_ctrl_pkg::ex_bundle_t   ex,
  input  ex_data_pkg::flags_t       flags_fwd,
  input  ex_data_pkg::word_t        count_fwd,
  input  logic                      wb_stall,
  input  logic                      repne_terminate,
  output ex_ctrl_pkg::wb_bundle_t   wb,
  output ex_ctrl_pkg::dep_enables_t dep,
  output logic                      ld_latches
);

  import ex_data_pkg::*;
  import ex_ctrl_pkg::*;

  word_t      b_eff;
  word_t      count;
  word_t      alu_result;
  word_t      shift_result;
  word_t      count_minus_one;
  word_t      sp_pop;
  word_t      result_a;
  word_t      result_b;
  word_t      result_c;
  flags_t     alu_flags;
  flags_t     shift_flags;
  flags_t     flags;
  mm_t        mm_result;
  mm_t        result_mm;
  logic       ld_gpr1;
  logic       ld_gpr2;
  logic       dcache_write;
  wb_bundle_t next_wb;

  operand_select_ex u_operand_select_ex (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .ctrl       (ex.ctrl),
    .valid      (ex.valid),
    .ld_latches (ld_latches),
    .b_in       (ex.b),
    .c_in       (ex.c),
    .count_fwd  (count_fwd),
    .b_eff      (b_eff),
    .count      (count)
  );

  functional_unit_ex u_functional_unit_ex (
    .aluk            (ex.aluk),
    .datasize        (ex.datasize),
    .ctrl            (ex.ctrl),
    .a               (ex.a),
    .b_eff           (b_eff),
    .c               (ex.c),
    .count           (count),
    .flags_fwd       (flags_fwd),
    .mm_a            (ex.mm_a),
    .mm_b            (ex.mm_b),
    .alu_result      (alu_result),
    .alu_flags       (alu_flags),
    .shift_result    (shift_result),
    .shift_flags     (shift_flags),
    .count_minus_one (count_minus_one),
    .sp_pop          (sp_pop),
    .mm_result       (mm_result)
  );

  result_select_ex u_result_select_ex (
    .ctrl            (ex.ctrl),
    .a               (ex.a),
    .b_eff           (b_eff),
    .c               (ex.c),
    .flags_fwd       (flags_fwd),
    .alu_result      (alu_result),
    .alu_flags       (alu_flags),
    .shift_result    (shift_result),
    .shift_flags     (shift_flags),
    .count_minus_one (count_minus_one),
    .sp_pop          (sp_pop),
    .mm_result       (mm_result),
    .result_a        (result_a),
    .result_b        (result_b),
    .result_c        (result_c),
    .flags           (flags),
    .result_mm       (result_mm)
  );

  write_enable_ex u_write_enable_ex (
    .ctrl         (ex.ctrl),
    .valid        (ex.valid),
    .alu_flags    (alu_flags),
    .ld_gpr1      (ld_gpr1),
    .ld_gpr2      (ld_gpr2),
    .dcache_write (dcache_write),
    .dep          (dep)
  );

  // next writeback bundle, uop identity passes through from ex
  always_comb begin
    next_wb.valid        = ex.valid;
    next_wb.neip         = ex.neip;
    next_wb.ncs          = ex.ncs;
    next_wb.ctrl         = ex.ctrl;
    next_wb.datasize     = ex.datasize;
    next_wb.ld_gpr1      = ld_gpr1;
    next_wb.ld_gpr2      = ld_gpr2;
    next_wb.dcache_write = dcache_write;
    next_wb.result_a     = result_a;
    next_wb.result_b     = result_b;
    next_wb.result_c     = result_c;
    next_wb.flags        = flags;
    next_wb.result_mm    = result_mm;
    next_wb.dr1          = ex.dr1;
    next_wb.dr2          = ex.dr2;
    next_wb.dr3          = ex.dr3;
    next_wb.address      = ex.address;
  end

  ex_wb_latch u_ex_wb_latch (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .next            (next_wb),
    .repne           (ex.ctrl.repne),
    .repne_terminate (repne_terminate),
    .wb_stall        (wb_stall),
    .wb              (wb),
    .ld_latches      (ld_latches)
  );

endmodule

//--- tb/execute_checker.sv
`timescale 1ns/1ps

module execute_checker (
  input logic                    CLK,
  input logic                    rst_n,
  input ex_ctrl_pkg::ex_bundle_t ex,
  input logic                    wb_stall,
  input logic                    repne_terminate,
  input logic                    ld_latches,
  input ex_ctrl_pkg::wb_bundle_t wb
);

  int assert_fails = 0;

  // first load after reset release carries no valid uop
  a_reset_invalid: assert property (@(posedge CLK)
    ($rose(rst_n) && !ex.valid) |=> !wb.valid)
    else begin
      assert_fails++;
      $error("wb.valid is set after reset without a valid uop");
    end

  // whole bundle frozen while writeback stalls
  a_stall_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    wb_stall |=> $stable(wb))
    else begin
      assert_fails++;
      $error("wb changed during a writeback stall");
    end

  a_ld_latches: assert property (@(posedge CLK) ld_latches == !wb_stall)
    else begin
      assert_fails++;
      $error("ld_latches is not the inverse of wb_stall");
    end

  a_repne_bubble: assert property (@(posedge CLK) disable iff (!rst_n)
    (ex.valid && ex.ctrl.repne && repne_terminate && ld_latches) |=> !wb.valid)
    else begin
      assert_fails++;
      $error("terminated repne uop reached writeback as valid");
    end

endmodule

bind execute execute_checker u_execute_checker (
  .CLK             (CLK),
  .rst_n           (rst_n),
  .ex              (ex),
  .wb_stall        (wb_stall),
  .repne_terminate (repne_terminate),
  .ld_latches      (ld_latches),
  .wb              (wb)
);

//--- tb/execute_monitor.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module execute_monitor (
  input logic                      CLK,
  input logic                      rst_n,
  input ex_ctrl_pkg::ex_bundle_t   ex,
  input ex_data_pkg::flags_t       flags_fwd,
  input ex_data_pkg::word_t        count_fwd,
  input logic                      wb_stall,
  input logic                      repne_terminate,
  input ex_ctrl_pkg::wb_bundle_t   wb,
  input ex_ctrl_pkg::dep_enables_t dep,
  input logic                      ld_latches
);

  import ex_data_pkg::*;
  import ex_ctrl_pkg::*;

  wb_bundle_t exp_wb;
  wb_bundle_t nxt;
  word_t      saved_b;
  logic       loaded;
  int         test_checks = 0;
  int         test_errors = 0;
  int         check_total = 0;
  int         error_total = 0;

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    test_checks++;
    check_total++;
    if (exp !== act) begin
      test_errors++;
      error_total++;
      $display("ERROR %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_test(input string name);
    $display("done: %s, %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // x86 add, sub and logic at the operand size
  function automatic void alu_model(input ex_bundle_t e, input word_t bsel, input flags_t ff,
                                    output word_t res, output flags_t fl);
    int          n;
    alu_op_t     op;
    logic [63:0] m;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] full;
    n    = (e.datasize == size8) ? 8 : ((e.datasize == size16) ? 16 : 32);
    m    = (64'd1 << n) - 64'd1;
    op   = e.ctrl.is_cmpxchg ? alu_sub : e.aluk;
    x    = 64'(e.ctrl.is_cmpxchg ? e.c : e.a) & m;
    y    = 64'(e.ctrl.is_cmpxchg ? e.a : bsel) & m;
    case (op)
      alu_add: full = x + y;
      alu_adc: full = x + y + 64'(ff[`EX_FLAG_CF]);
      alu_sub: full = x - y;
      alu_and: full = x & y;
      alu_or:  full = x | y;
      alu_xor: full = x ^ y;
      alu_not: full = ~x;
      default: full = y;
    endcase
    res             = 32'(full & m);
    fl              = ff;
    fl[`EX_FLAG_ZF] = (res == '0);
    fl[`EX_FLAG_SF] = full[n-1];
    fl[`EX_FLAG_CF] = 1'b0;
    fl[`EX_FLAG_OF] = 1'b0;
    if (op == alu_add || op == alu_adc) begin
      fl[`EX_FLAG_CF] = full[n];
      fl[`EX_FLAG_OF] = (x[n-1] == y[n-1]) && (full[n-1] != x[n-1]);
    end else if (op == alu_sub) begin
      fl[`EX_FLAG_CF] = full[n];
      fl[`EX_FLAG_OF] = (x[n-1] != y[n-1]) && (full[n-1] != x[n-1]);
    end
  endfunction

  function automatic void shift_model(input word_t a, input word_t b, input shift_op_t sop,
                                      input flags_t ff, output word_t res, output flags_t fl);
    int   s;
    logic co;
    s   = int'(b[`EX_SHAMT_W-1:0]);
    res = a;
    fl  = ff;
    if (s != 0) begin
      case (sop)
        shift_shl: begin
          res             = a << s;
          co              = a[32-s];
          fl[`EX_FLAG_OF] = res[31] ^ co;
        end
        shift_shr: begin
          res             = a >> s;
          co              = a[s-1];
          fl[`EX_FLAG_OF] = a[31];
        end
        default: begin
          res             = word_t'($signed(a) >>> s);
          co              = a[s-1];
          fl[`EX_FLAG_OF] = 1'b0;
        end
      endcase
      fl[`EX_FLAG_CF] = co;
      fl[`EX_FLAG_ZF] = (res == '0);
      fl[`EX_FLAG_SF] = res[31];
    end
  endfunction

  function automatic wb_bundle_t predict(input ex_bundle_t e, input flags_t ff,
                                         input word_t cfwd, input logic term,
                                         input word_t saved);
    wb_bundle_t w;
    word_t      bsel;
    word_t      cnt;
    word_t      alu_r;
    word_t      sh_r;
    flags_t     alu_f;
    flags_t     sh_f;
    bsel = e.ctrl.is_cmps_second ? saved : e.b;
    cnt  = e.ctrl.repne ? cfwd : e.c;
    alu_model(e, bsel, ff, alu_r, alu_f);
    shift_model(e.a, bsel, e.ctrl.shift_op, ff, sh_r, sh_f);
    w              = '0;
    w.valid        = e.valid && !(e.ctrl.repne && term);
    w.neip         = e.neip;
    w.ncs          = e.ncs;
    w.ctrl         = e.ctrl;
    w.datasize     = e.datasize;
    w.dr1          = e.dr1;
    w.dr2          = e.dr2;
    w.dr3          = e.dr3;
    w.address      = e.address;
    w.ld_gpr1      = e.ctrl.ld_gpr1;
    w.ld_gpr2      = e.ctrl.ld_gpr2;
    w.dcache_write = e.ctrl.dcache_write;
    // a failed compare reloads the accumulator only
    if (e.ctrl.is_cmpxchg) begin
      w.ld_gpr2 = !alu_f[`EX_FLAG_ZF];
      if (!alu_f[`EX_FLAG_ZF]) begin
        w.ld_gpr1      = 1'b0;
        w.dcache_write = 1'b0;
      end
    end
    w.result_a = e.ctrl.is_shift ? sh_r : (e.ctrl.is_alu32 ? alu_r :
                 (e.ctrl.is_xchg ? bsel : e.a));
    if (e.ctrl.is_xchg || e.ctrl.is_cmpxchg) begin
      w.result_b = e.a;
    end else if (e.ctrl.mux_sp_pop) begin
      w.result_b = e.a + ((e.datasize == size16) ? 32'd2 : 32'd4);
    end else begin
      w.result_b = bsel;
    end
    w.result_c = (e.ctrl.repne || e.ctrl.is_cmps_second) ? cnt - 32'd1 : e.c;
    w.flags    = e.ctrl.is_shift ? sh_f : (e.ctrl.is_alu32 ? alu_f : ff);
    for (int k = 0; k < 4; k++) begin
      w.result_mm[16*k +: 16] = e.mm_a[16*k +: 16] + e.mm_b[16*k +: 16];
    end
    return w;
  endfunction

  function automatic dep_enables_t dep_model(input ex_bundle_t e, input wb_bundle_t w);
    dep_enables_t d;
    d.gpr1         = w.ld_gpr1 & e.valid;
    d.gpr2         = w.ld_gpr2 & e.valid;
    d.gpr3         = e.ctrl.ld_gpr3 & e.valid;
    d.seg          = e.ctrl.ld_seg & e.valid;
    d.mm           = e.ctrl.ld_mm & e.valid;
    d.dcache_write = w.dcache_write & e.valid;
    return d;
  endfunction

  // wb still shows the previous load here, ex was driven at the falling edge
  always @(posedge CLK) begin
    nxt = predict(ex, flags_fwd, count_fwd, repne_terminate, saved_b);
    if (!rst_n) begin
      exp_wb  = '0;
      saved_b = '0;
      loaded  = 1'b0;
    end else begin
      check_value("wb.valid", 128'(exp_wb.valid), 128'(wb.valid));
      check_value("wb.ld_gpr1", 128'(exp_wb.ld_gpr1), 128'(wb.ld_gpr1));
      check_value("wb.ld_gpr2", 128'(exp_wb.ld_gpr2), 128'(wb.ld_gpr2));
      check_value("wb.dcache_write", 128'(exp_wb.dcache_write), 128'(wb.dcache_write));
      if (loaded) begin
        check_value("wb.result_a", 128'(exp_wb.result_a), 128'(wb.result_a));
        check_value("wb.result_b", 128'(exp_wb.result_b), 128'(wb.result_b));
        check_value("wb.result_c", 128'(exp_wb.result_c), 128'(wb.result_c));
        check_value("wb.flags", 128'(exp_wb.flags), 128'(wb.flags));
        check_value("wb.result_mm", 128'(exp_wb.result_mm), 128'(wb.result_mm));
        check_value("wb.neip_ncs_ctrl_size_dr_address",
                    128'({exp_wb.neip, exp_wb.ncs, exp_wb.ctrl, exp_wb.datasize,
                          exp_wb.dr1, exp_wb.dr2, exp_wb.dr3, exp_wb.address}),
                    128'({wb.neip, wb.ncs, wb.ctrl, wb.datasize,
                          wb.dr1, wb.dr2, wb.dr3, wb.address}));
      end
      check_value("dep", 128'(dep_model(ex, nxt)), 128'(dep));
      check_value("ld_latches", 128'(!wb_stall), 128'(ld_latches));
      if (!wb_stall) begin
        exp_wb = nxt;
        loaded = 1'b1;
        if (ex.valid && ex.ctrl.is_cmps_first) begin
          saved_b = ex.b;
        end
      end
    end
  end

endmodule

//--- tb/execute_tb.sv
`timescale 1ns/1ps

module execute_tb;

  import ex_data_pkg::*;
  import ex_ctrl_pkg::*;

  localparam int test_len    = 200;
  localparam int num_tests   = 5;
  localparam int reset_len   = 16;
  // each test adds three idle cycles after its uops
  localparam int cycle_limit = 2 * (num_tests * (test_len + 3) + reset_len);

  logic         CLK;
  logic         rst_n;
  ex_bundle_t   ex;
  flags_t       flags_fwd;
  word_t        count_fwd;
  logic         wb_stall;
  logic         repne_terminate;
  wb_bundle_t   wb;
  dep_enables_t dep;
  logic         ld_latches;
  logic [31:0]  lfsr;
  int           cycles = 0;
  int           total_errors;

  execute u_execute (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .ex              (ex),
    .flags_fwd       (flags_fwd),
    .count_fwd       (count_fwd),
    .wb_stall        (wb_stall),
    .repne_terminate (repne_terminate),
    .wb              (wb),
    .dep             (dep),
    .ld_latches      (ld_latches)
  );

  execute_monitor u_execute_monitor (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .ex              (ex),
    .flags_fwd       (flags_fwd),
    .count_fwd       (count_fwd),
    .wb_stall        (wb_stall),
    .repne_terminate (repne_terminate),
    .wb              (wb),
    .dep             (dep),
    .ld_latches      (ld_latches)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  function automatic ex_bundle_t make_uop(input int kind, input int idx);
    ex_bundle_t e;
    logic [2:0] sub;
    logic [1:0] two;
    e          = '0;
    e.valid    = 1'b1;
    e.neip     = 32'(rnd(32));
    e.ncs      = 16'(rnd(16));
    e.a        = 32'(rnd(32));
    e.b        = 32'(rnd(32));
    e.c        = 32'(rnd(32));
    e.mm_a     = rnd(64);
    e.mm_b     = rnd(64);
    e.dr1      = 3'(rnd(3));
    e.dr2      = 3'(rnd(3));
    e.dr3      = 3'(rnd(3));
    e.address  = 32'(rnd(32));
    e.aluk     = alu_op_t'(3'(rnd(3)));
    two        = 2'(rnd(2));
    e.datasize = datasize_t'((two == 2'd3) ? 2'd2 : two);
    {e.ctrl.ld_gpr1, e.ctrl.ld_gpr2, e.ctrl.ld_gpr3,
     e.ctrl.ld_seg, e.ctrl.ld_mm, e.ctrl.dcache_write} = 6'(rnd(6));
    case (kind)
      1: e.ctrl.is_alu32 = 1'b1;
      2: begin
        sub = 3'(rnd(3));
        if (sub < 3'd2) begin
          e.ctrl.is_shift = 1'b1;
          two             = 2'(rnd(2));
          e.ctrl.shift_op = shift_op_t'((two == 2'd3) ? 2'd0 : two);
        end else if (sub == 3'd2) begin
          e.ctrl.mux_sp_pop = 1'b1;
        end else if (sub == 3'd3) begin
          e.ctrl.is_xchg = 1'b1;
        end else if (sub == 3'd4) begin
          e.ctrl.pass_a = 1'b1;
        end else begin
          // paddw
          e.ctrl.ld_mm = 1'b1;
        end
      end
      3: begin
        e.ctrl.is_cmpxchg = 1'b1;
        e.ctrl.is_alu32   = 1'(rnd(1));
        // equal operands half the time
        if (rnd(1) != 0) begin
          e.c = e.a;
        end
      end
      default: begin
        e.ctrl.is_alu32 = 1'b1;
        e.aluk          = alu_sub;
        e.ctrl.repne    = 1'(rnd(1));
        if (idx % 2 == 0) begin
          e.ctrl.is_cmps_first = 1'b1;
        end else begin
          e.ctrl.is_cmps_second = 1'b1;
        end
      end
    endcase
    return e;
  endfunction

  task automatic run_test(input int kind, input string name);
    int k;
    for (int i = 0; i < test_len; i++) begin
      @(negedge CLK);
      flags_fwd = 32'(rnd(32));
      count_fwd = 32'(rnd(32));
      if (kind == 5) begin
        // upstream holds ex while writeback stalls
        if (!wb_stall) begin
          k            = 1 + int'(rnd(2));
          ex           = make_uop(k, i);
          ex.valid     = (rnd(2) != 0);
          ex.ctrl.repne = ex.ctrl.repne | 1'(rnd(1));
        end
        wb_stall        = (rnd(2) == 0);
        repne_terminate = 1'(rnd(1));
      end else begin
        ex = make_uop(kind, i);
      end
    end
    @(negedge CLK);
    ex              = '0;
    wb_stall        = 1'b0;
    repne_terminate = 1'b0;
    repeat (2) @(negedge CLK);
    u_execute_monitor.report_test(name);
  endtask

  initial begin
    CLK             = 1'b0;
    rst_n           = 1'b0;
    ex              = '0;
    flags_fwd       = '0;
    count_fwd       = '0;
    wb_stall        = 1'b0;
    repne_terminate = 1'b0;
    lfsr            = 32'd41;
    repeat (reset_len) @(negedge CLK);
    rst_n = 1'b1;

    run_test(1, "alu32 ops");
    run_test(2, "shift pop xchg mmx");
    run_test(3, "cmpxchg");
    run_test(4, "cmps and repne");
    run_test(5, "stall and terminate");

    total_errors = u_execute_monitor.error_total + u_execute.u_execute_checker.assert_fails;
    $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
             u_execute_monitor.check_total, u_execute_monitor.error_total,
             u_execute.u_execute_checker.assert_fails);
    if (total_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+design
design/ex_data_pkg.sv
design/ex_ctrl_pkg.sv
design/operand_select_ex.sv
design/functional_unit_ex.sv
design/result_select_ex.sv
design/write_enable_ex.sv
design/ex_wb_latch.sv
design/execute.sv
tb/execute_checker.sv
tb/execute_monitor.sv
tb/execute_tb.sv

//--- Bender.yml
package:
  name: execute

sources:
  - include_dirs:
      - design
    files:
      - design/ex_data_pkg.sv
      - design/ex_ctrl_pkg.sv
      - design/operand_select_ex.sv
      - design/functional_unit_ex.sv
      - design/result_select_ex.sv
      - design/write_enable_ex.sv
      - design/ex_wb_latch.sv
      - design/execute.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/execute_checker.sv
      - tb/execute_monitor.sv
      - tb/execute_tb.sv
